// File: hdl/mips_pkg.sv
package mips_pkg;

    localparam int data_width = 32;

    // major opcodes
    localparam logic [5:0] op_r_type  = 6'b000000;
    localparam logic [5:0] op_branchs = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lb      = 6'b100000;
    localparam logic [5:0] op_lh      = 6'b100001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_lbu     = 6'b100100;
    localparam logic [5:0] op_lhu     = 6'b100101;
    localparam logic [5:0] op_sb      = 6'b101000;
    localparam logic [5:0] op_sh      = 6'b101001;
    localparam logic [5:0] op_sw      = 6'b101011;

    // r-type function codes
    localparam logic [5:0] fn_sll   = 6'b000000;
    localparam logic [5:0] fn_srl   = 6'b000010;
    localparam logic [5:0] fn_sra   = 6'b000011;
    localparam logic [5:0] fn_sllv  = 6'b000100;
    localparam logic [5:0] fn_srlv  = 6'b000110;
    localparam logic [5:0] fn_srav  = 6'b000111;
    localparam logic [5:0] fn_jr    = 6'b001000;
    localparam logic [5:0] fn_mthi  = 6'b010001;
    localparam logic [5:0] fn_mtlo  = 6'b010011;
    localparam logic [5:0] fn_mult  = 6'b011000;
    localparam logic [5:0] fn_multu = 6'b011001;
    localparam logic [5:0] fn_div   = 6'b011010;
    localparam logic [5:0] fn_divu  = 6'b011011;
    localparam logic [5:0] fn_add   = 6'b100000;
    localparam logic [5:0] fn_addu  = 6'b100001;
    localparam logic [5:0] fn_sub   = 6'b100010;
    localparam logic [5:0] fn_subu  = 6'b100011;
    localparam logic [5:0] fn_and   = 6'b100100;
    localparam logic [5:0] fn_or    = 6'b100101;
    localparam logic [5:0] fn_xor   = 6'b100110;
    localparam logic [5:0] fn_nor   = 6'b100111;
    localparam logic [5:0] fn_slt   = 6'b101010;
    localparam logic [5:0] fn_sltu  = 6'b101011;

    // rt selectors under op_branchs
    localparam logic [4:0] rt_bltz   = 5'b00000;
    localparam logic [4:0] rt_bgez   = 5'b00001;
    localparam logic [4:0] rt_bltzal = 5'b10000;
    localparam logic [4:0] rt_bgezal = 5'b10001;

    typedef enum logic [4:0] {
        alu_nop, alu_and, alu_or, alu_xor, alu_nor, alu_xnor,
        alu_add, alu_addu, alu_sub, alu_subu, alu_slt, alu_sltu,
        alu_sll_sa, alu_srl_sa, alu_sra_sa, alu_sll, alu_srl, alu_sra,
        alu_lui, alu_mult, alu_multu, alu_mthi, alu_mtlo,
        alu_eqz, alu_gtz, alu_lez, alu_ltz, alu_gez
    } alu_op_e;

endpackage

// File: hdl/ex_stage_if.sv
// id/ex pipeline register contents, one instruction per valid cycle
interface ex_stage_if (
    input logic clk
);

    logic                              valid;
    mips_pkg::alu_op_e                 op;
    logic [mips_pkg::data_width-1:0]   src_a;
    logic [mips_pkg::data_width-1:0]   src_b;
    logic [4:0]                        sa;

    modport decoder (
        input  clk,
        output valid, op, src_a, src_b, sa
    );

    modport execute (
        input  clk,
        input  valid, op, src_a, src_b, sa
    );

endinterface

// File: hdl/alu_decoder.sv
module alu_decoder (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             instr_valid,
    input  logic [31:0]                      instr,
    input  logic [mips_pkg::data_width-1:0]  rs_value,
    input  logic [mips_pkg::data_width-1:0]  rt_value,
    ex_stage_if.decoder                      ex
);

    typedef enum logic [1:0] {b_rt, b_sext, b_zext, b_upper} b_sel_e;

    logic [5:0]                      opcode;
    logic [4:0]                      rt_field;
    logic [5:0]                      funct;
    logic [15:0]                     imm;
    mips_pkg::alu_op_e               op_d;
    logic                            a_from_rt;
    b_sel_e                          b_sel;
    logic [mips_pkg::data_width-1:0] src_b_d;

    assign opcode   = instr[31:26];
    assign rt_field = instr[20:16];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];

    always_comb begin
        op_d      = mips_pkg::alu_nop;
        a_from_rt = 1'b0;
        b_sel     = b_rt;
        case (opcode)
            mips_pkg::op_r_type: begin
                case (funct)
                    mips_pkg::fn_and:   op_d = mips_pkg::alu_and;
                    mips_pkg::fn_or:    op_d = mips_pkg::alu_or;
                    mips_pkg::fn_xor:   op_d = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:   op_d = mips_pkg::alu_nor;
                    mips_pkg::fn_add:   op_d = mips_pkg::alu_add;
                    mips_pkg::fn_addu:  op_d = mips_pkg::alu_addu;
                    mips_pkg::fn_sub:   op_d = mips_pkg::alu_sub;
                    mips_pkg::fn_subu:  op_d = mips_pkg::alu_subu;
                    mips_pkg::fn_slt:   op_d = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu:  op_d = mips_pkg::alu_sltu;
                    mips_pkg::fn_mult:  op_d = mips_pkg::alu_mult;
                    mips_pkg::fn_multu: op_d = mips_pkg::alu_multu;
                    mips_pkg::fn_mthi:  op_d = mips_pkg::alu_mthi;
                    mips_pkg::fn_mtlo:  op_d = mips_pkg::alu_mtlo;
                    mips_pkg::fn_sllv:  op_d = mips_pkg::alu_sll;
                    mips_pkg::fn_srlv:  op_d = mips_pkg::alu_srl;
                    mips_pkg::fn_srav:  op_d = mips_pkg::alu_sra;
                    // immediate shifts take their value from rt
                    mips_pkg::fn_sll: begin
                        op_d      = mips_pkg::alu_sll_sa;
                        a_from_rt = 1'b1;
                    end
                    mips_pkg::fn_srl: begin
                        op_d      = mips_pkg::alu_srl_sa;
                        a_from_rt = 1'b1;
                    end
                    mips_pkg::fn_sra: begin
                        op_d      = mips_pkg::alu_sra_sa;
                        a_from_rt = 1'b1;
                    end
                    // jr, div, divu fall through as nop
                    default:            op_d = mips_pkg::alu_nop;
                endcase
            end
            mips_pkg::op_addi:  {op_d, b_sel} = {mips_pkg::alu_add, b_sext};
            mips_pkg::op_addiu: {op_d, b_sel} = {mips_pkg::alu_addu, b_sext};
            mips_pkg::op_slti:  {op_d, b_sel} = {mips_pkg::alu_slt, b_sext};
            mips_pkg::op_sltiu: {op_d, b_sel} = {mips_pkg::alu_sltu, b_sext};
            mips_pkg::op_andi:  {op_d, b_sel} = {mips_pkg::alu_and, b_zext};
            mips_pkg::op_ori:   {op_d, b_sel} = {mips_pkg::alu_or, b_zext};
            mips_pkg::op_xori:  {op_d, b_sel} = {mips_pkg::alu_xor, b_zext};
            mips_pkg::op_lui:   {op_d, b_sel} = {mips_pkg::alu_lui, b_upper};
            // address generation, no overflow trap
            mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw, mips_pkg::op_lbu,
            mips_pkg::op_lhu, mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw:
                {op_d, b_sel} = {mips_pkg::alu_addu, b_sext};
            mips_pkg::op_beq:   op_d = mips_pkg::alu_xnor;
            mips_pkg::op_bne:   op_d = mips_pkg::alu_xor;
            mips_pkg::op_bgtz:  op_d = mips_pkg::alu_gtz;
            mips_pkg::op_blez:  op_d = mips_pkg::alu_lez;
            mips_pkg::op_branchs: begin
                case (rt_field)
                    mips_pkg::rt_bltz, mips_pkg::rt_bltzal: op_d = mips_pkg::alu_ltz;
                    mips_pkg::rt_bgez, mips_pkg::rt_bgezal: op_d = mips_pkg::alu_gez;
                    default:                                op_d = mips_pkg::alu_nop;
                endcase
            end
            default: op_d = mips_pkg::alu_nop;
        endcase
    end

    always_comb begin
        case (b_sel)
            b_sext:  src_b_d = {{16{imm[15]}}, imm};
            b_zext:  src_b_d = {16'b0, imm};
            b_upper: src_b_d = {imm, 16'b0};
            default: src_b_d = rt_value;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= instr_valid;
        end
    end

    // payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex.op    <= op_d;
            ex.src_a <= a_from_rt ? rt_value : rs_value;
            ex.src_b <= src_b_d;
            ex.sa    <= instr[10:6];
        end
    end

    a_op_known: assert property (@(posedge ex.clk) disable iff (!arst_n)
        ex.valid |-> !$isunknown(ex.op));

endmodule

// File: hdl/alu.sv
module alu (
    input  logic                             clk,
    input  logic                             arst_n,
    ex_stage_if.execute                      ex,
    output logic                             result_valid,
    output logic [mips_pkg::data_width-1:0]  result,
    output logic                             branch_cond,
    output logic                             overflow
);

    logic [mips_pkg::data_width-1:0] a;
    logic [mips_pkg::data_width-1:0] b;
    logic [mips_pkg::data_width-1:0] sum;
    logic [mips_pkg::data_width-1:0] diff;
    logic [4:0]                      shamt_v;
    logic                            sign_a;
    logic                            sign_b;
    logic [mips_pkg::data_width-1:0] res_d;
    logic                            cond_d;
    logic                            ovf_d;

    assign a       = ex.src_a;
    assign b       = ex.src_b;
    assign sum     = a + b;
    assign diff    = a - b;
    assign shamt_v = a[4:0];
    assign sign_a  = a[mips_pkg::data_width-1];
    assign sign_b  = b[mips_pkg::data_width-1];

    always_comb begin
        res_d  = '0;
        cond_d = 1'b0;
        ovf_d  = 1'b0;
        case (ex.op)
            mips_pkg::alu_and: res_d = a & b;
            mips_pkg::alu_or:  res_d = a | b;
            mips_pkg::alu_nor: res_d = ~(a | b);
            // bne shares xor, the flag marks inequality
            mips_pkg::alu_xor: begin
                res_d  = a ^ b;
                cond_d = (a != b);
            end
            mips_pkg::alu_xnor: cond_d = (a == b);
            mips_pkg::alu_add: begin
                res_d = sum;
                ovf_d = (sign_a == sign_b) && (sum[mips_pkg::data_width-1] != sign_a);
            end
            mips_pkg::alu_addu: res_d = sum;
            mips_pkg::alu_sub: begin
                res_d = diff;
                ovf_d = (sign_a != sign_b) && (diff[mips_pkg::data_width-1] != sign_a);
            end
            mips_pkg::alu_subu:   res_d = diff;
            mips_pkg::alu_slt:    res_d[0] = $signed(a) < $signed(b);
            mips_pkg::alu_sltu:   res_d[0] = a < b;
            mips_pkg::alu_sll_sa: res_d = a << ex.sa;
            mips_pkg::alu_srl_sa: res_d = a >> ex.sa;
            mips_pkg::alu_sra_sa: res_d = $signed(a) >>> ex.sa;
            mips_pkg::alu_sll:    res_d = b << shamt_v;
            mips_pkg::alu_srl:    res_d = b >> shamt_v;
            mips_pkg::alu_sra:    res_d = $signed(b) >>> shamt_v;
            mips_pkg::alu_lui:    res_d = b;
            mips_pkg::alu_eqz:    cond_d = (a == '0);
            mips_pkg::alu_gtz:    cond_d = !sign_a && (a != '0);
            mips_pkg::alu_lez:    cond_d = sign_a || (a == '0);
            mips_pkg::alu_ltz:    cond_d = sign_a;
            mips_pkg::alu_gez:    cond_d = !sign_a;
            // nop and the hi/lo ops give zero
            default:              res_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            branch_cond  <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            result_valid <= ex.valid;
            branch_cond  <= ex.valid && cond_d;
            overflow     <= ex.valid && ovf_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            result <= res_d;
        end
    end

    // wrapped sum flips sign against the first operand
    a_ovf_valid: assert property (@(posedge clk) disable iff (!arst_n)
        overflow |-> result_valid
            && (result[mips_pkg::data_width-1] != $past(ex.src_a[mips_pkg::data_width-1])));
    // only bne/xor leaves a nonzero result next to a taken condition
    a_cond_valid: assert property (@(posedge clk) disable iff (!arst_n)
        branch_cond |-> result_valid
            && (($past(ex.op) == mips_pkg::alu_xor) == (result != '0)));

endmodule

// File: hdl/hilo_unit.sv
module hilo_unit (
    input  logic                             clk,
    input  logic                             arst_n,
    ex_stage_if.execute                      ex,
    output logic [mips_pkg::data_width-1:0]  hi,
    output logic [mips_pkg::data_width-1:0]  lo
);

    logic signed [2*mips_pkg::data_width-1:0] prod_s;
    logic        [2*mips_pkg::data_width-1:0] prod_u;

    // operands widen to 64 bits before the multiply
    assign prod_s = $signed(ex.src_a) * $signed(ex.src_b);
    assign prod_u = ex.src_a * ex.src_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (ex.valid) begin
            case (ex.op)
                mips_pkg::alu_mult: begin
                    hi <= prod_s[2*mips_pkg::data_width-1:mips_pkg::data_width];
                    lo <= prod_s[mips_pkg::data_width-1:0];
                end
                mips_pkg::alu_multu: begin
                    hi <= prod_u[2*mips_pkg::data_width-1:mips_pkg::data_width];
                    lo <= prod_u[mips_pkg::data_width-1:0];
                end
                mips_pkg::alu_mthi: hi <= ex.src_a;
                mips_pkg::alu_mtlo: lo <= ex.src_a;
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // a bubble or an unrelated op never touches hi/lo
    a_hi_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !(ex.valid && ex.op inside {mips_pkg::alu_mult, mips_pkg::alu_multu,
            mips_pkg::alu_mthi}) |=> $stable(hi));
    a_lo_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !(ex.valid && ex.op inside {mips_pkg::alu_mult, mips_pkg::alu_multu,
            mips_pkg::alu_mtlo}) |=> $stable(lo));

endmodule

// File: hdl/exec_slice.sv
module exec_slice (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             instr_valid,
    input  logic [31:0]                      instr,
    input  logic [mips_pkg::data_width-1:0]  rs_value,
    input  logic [mips_pkg::data_width-1:0]  rt_value,
    output logic                             result_valid,
    output logic [mips_pkg::data_width-1:0]  result,
    output logic                             branch_cond,
    output logic                             overflow,
    output logic [mips_pkg::data_width-1:0]  hi,
    output logic [mips_pkg::data_width-1:0]  lo
);

    ex_stage_if i_ex (.clk(clk));

    alu_decoder i_dec (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .ex          (i_ex.decoder)
    );

    alu i_alu (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex           (i_ex.execute),
        .result_valid (result_valid),
        .result       (result),
        .branch_cond  (branch_cond),
        .overflow     (overflow)
    );

    // hi/lo sits alongside the alu in execute
    hilo_unit i_hilo (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (i_ex.execute),
        .hi     (hi),
        .lo     (lo)
    );

endmodule

// File: test/exec_slice_tb.sv
module exec_slice_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_wait = 20;
    localparam logic [5:0] mix_fn [5] = '{mips_pkg::fn_addu, mips_pkg::fn_subu,
        mips_pkg::fn_xor, mips_pkg::fn_sltu, mips_pkg::fn_srav};

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] res;
        logic        cond;
        logic        ovf;
        logic        hl;
        logic [31:0] hi;
        logic [31:0] lo;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        result_valid;
    logic [31:0] result;
    logic        branch_cond;
    logic        overflow;
    logic [31:0] hi;
    logic [31:0] lo;

    row_t        rows[$];
    logic [32:0] expect_q[$];
    logic [15:0] lfsr;

    exec_slice i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] rtype(logic [5:0] fn, logic [4:0] sa);
        return {6'd0, 15'd0, sa, fn};
    endfunction

    function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rt, logic [15:0] imm);
        return {op, 5'd0, rt, imm};
    endfunction

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // result rules for the random mix, returns {branch_cond, result}
    function automatic logic [32:0] model(logic [5:0] fn, logic [31:0] a, logic [31:0] b);
        case (fn)
            mips_pkg::fn_addu: return {1'b0, a + b};
            mips_pkg::fn_subu: return {1'b0, a - b};
            mips_pkg::fn_xor:  return {a != b, a ^ b};
            mips_pkg::fn_sltu: return {1'b0, 31'd0, a < b};
            default:           return {1'b0, $signed(b) >>> a[4:0]};
        endcase
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic add_row(input logic [31:0] ins, rs, rt, res, input logic cond, ovf);
        rows.push_back('{ins, rs, rt, res, cond, ovf, 1'b0, 32'h0, 32'h0});
    endtask

    task automatic add_hilo_row(input logic [31:0] ins, rs, rt, exp_hi, exp_lo);
        rows.push_back('{ins, rs, rt, 32'h0, 1'b0, 1'b0, 1'b1, exp_hi, exp_lo});
    endtask

    // idle pipeline, flags low and hi/lo held
    task automatic idle_cycles(input int n, input logic [31:0] exp_hi, exp_lo);
        repeat (n) begin
            @(posedge clk);
            #1;
            check("result_valid", result_valid, 0);
            check("branch_cond", branch_cond, 0);
            check("overflow", overflow, 0);
            check("hi", hi, exp_hi);
            check("lo", lo, exp_lo);
        end
    endtask

    task automatic run_row(input row_t r);
        int cycles;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = r.instr;
        rs_value    = r.rs;
        rt_value    = r.rt;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        // the sampling edge is the first cycle after issue
        cycles      = 1;
        while (!result_valid && cycles < max_wait) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!result_valid) begin
            abort_run($sformatf("no result arrived for instruction %h", r.instr));
        end
        check("latency", cycles, 2);
        check("result", result, r.res);
        check("branch_cond", branch_cond, r.cond);
        check("overflow", overflow, r.ovf);
        if (r.hl) begin
            check("hi", hi, r.hi);
            check("lo", lo, r.lo);
        end
    endtask

    task automatic collect_result();
        logic [32:0] exp;
        if (result_valid) begin
            if (expect_q.size() == 0) begin
                abort_run("a result appeared with no instruction outstanding");
            end
            exp = expect_q.pop_front();
            check("stream result", result, exp[31:0]);
            check("stream branch_cond", branch_cond, exp[32]);
            check("stream overflow", overflow, 0);
        end
    endtask

    // one instruction per cycle, results must follow in issue order
    task automatic random_pass(input int n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        logic [5:0]  fn;
        int          issued;
        int          idle;
        issued = 0;
        idle   = 0;
        while (issued < n || expect_q.size() > 0) begin
            @(posedge clk);
            #1;
            collect_result();
            if (issued < n) begin
                draw_bits(32, a);
                draw_bits(32, b);
                draw_bits(3, sel);
                fn          = mix_fn[sel % 5];
                instr_valid = 1'b1;
                instr       = rtype(fn, 5'd0);
                rs_value    = a;
                rt_value    = b;
                expect_q.push_back(model(fn, a, b));
                issued++;
            end else begin
                instr_valid = 1'b0;
                idle++;
                if (idle > max_wait) begin
                    abort_run("no result arrived for the random instruction stream");
                end
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs_value    = '0;
        rt_value    = '0;
        lfsr        = 16'd40;

        add_row(rtype(mips_pkg::fn_add, 0), 32'h7fff_ffff, 32'h1, 32'h8000_0000, 0, 1);
        add_row(rtype(mips_pkg::fn_addu, 0), 32'h7fff_ffff, 32'h1, 32'h8000_0000, 0, 0);
        add_row(rtype(mips_pkg::fn_sub, 0), 32'h8000_0000, 32'h1, 32'h7fff_ffff, 0, 1);
        add_row(rtype(mips_pkg::fn_subu, 0), 32'h8000_0000, 32'h1, 32'h7fff_ffff, 0, 0);
        add_row(rtype(mips_pkg::fn_and, 0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'h00f0_0f00, 0, 0);
        add_row(rtype(mips_pkg::fn_or, 0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'hfff0_fff0, 0, 0);
        add_row(rtype(mips_pkg::fn_xor, 0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'hff00_f0f0, 1, 0);
        add_row(rtype(mips_pkg::fn_nor, 0), 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'h000f_000f, 0, 0);
        add_row(rtype(mips_pkg::fn_slt, 0), 32'hffff_ffff, 32'h1, 32'h1, 0, 0);
        add_row(rtype(mips_pkg::fn_sltu, 0), 32'hffff_ffff, 32'h1, 32'h0, 0, 0);
        add_row(rtype(mips_pkg::fn_sll, 5'd4), 32'h0, 32'h8000_00f1, 32'h0000_0f10, 0, 0);
        add_row(rtype(mips_pkg::fn_srl, 5'd4), 32'h0, 32'h8000_00f1, 32'h0800_000f, 0, 0);
        add_row(rtype(mips_pkg::fn_sra, 5'd4), 32'h0, 32'h8000_00f1, 32'hf800_000f, 0, 0);
        add_row(rtype(mips_pkg::fn_sllv, 0), 32'd24, 32'h0000_00ab, 32'hab00_0000, 0, 0);
        add_row(rtype(mips_pkg::fn_srlv, 0), 32'h104, 32'h8000_0000, 32'h0800_0000, 0, 0);
        add_row(rtype(mips_pkg::fn_srav, 0), 32'd31, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        add_row(itype(mips_pkg::op_addi, 0, 16'h0001), 32'h7fff_ffff, 0, 32'h8000_0000, 0, 1);
        add_row(itype(mips_pkg::op_addiu, 0, 16'h0001), 32'h7fff_ffff, 0, 32'h8000_0000, 0, 0);
        add_row(itype(mips_pkg::op_slti, 0, 16'hffff), 32'hffff_fffe, 0, 32'h1, 0, 0);
        add_row(itype(mips_pkg::op_sltiu, 0, 16'hffff), 32'hffff_fffe, 0, 32'h1, 0, 0);
        add_row(itype(mips_pkg::op_andi, 0, 16'h8f0f), 32'hffff_1234, 0, 32'h0000_0204, 0, 0);
        add_row(itype(mips_pkg::op_ori, 0, 16'h8001), 32'h1234_0000, 0, 32'h1234_8001, 0, 0);
        add_row(itype(mips_pkg::op_xori, 0, 16'h00ff), 32'hffff_ffff, 0, 32'hffff_ff00, 1, 0);
        add_row(itype(mips_pkg::op_lui, 0, 16'h8765), 32'h0, 0, 32'h8765_0000, 0, 0);
        add_row(itype(mips_pkg::op_lw, 0, 16'hfffc), 32'h0000_1000, 0, 32'h0000_0ffc, 0, 0);
        add_row(itype(mips_pkg::op_beq, 0, 16'h0), 32'd5, 32'd5, 32'h0, 1, 0);
        add_row(itype(mips_pkg::op_beq, 0, 16'h0), 32'd5, 32'd6, 32'h0, 0, 0);
        // bne shares the xor result
        add_row(itype(mips_pkg::op_bne, 0, 16'h0), 32'd5, 32'd6, 32'h3, 1, 0);
        add_row(itype(mips_pkg::op_bne, 0, 16'h0), 32'd5, 32'd5, 32'h0, 0, 0);
        add_row(itype(mips_pkg::op_bgtz, 0, 16'h0), 32'd1, 0, 32'h0, 1, 0);
        add_row(itype(mips_pkg::op_bgtz, 0, 16'h0), 32'd0, 0, 32'h0, 0, 0);
        add_row(itype(mips_pkg::op_blez, 0, 16'h0), 32'd0, 0, 32'h0, 1, 0);
        add_row(itype(mips_pkg::op_blez, 0, 16'h0), 32'd1, 0, 32'h0, 0, 0);
        add_row(itype(mips_pkg::op_branchs, mips_pkg::rt_bltz, 16'h0), 32'h8000_0000, 0, 0, 1, 0);
        add_row(itype(mips_pkg::op_branchs, mips_pkg::rt_bltzal, 16'h0), 32'h0, 0, 0, 0, 0);
        add_row(itype(mips_pkg::op_branchs, mips_pkg::rt_bgez, 16'h0), 32'h0, 0, 0, 1, 0);
        add_row(itype(mips_pkg::op_branchs, mips_pkg::rt_bgezal, 16'h0), 32'hffff_ffff, 0, 0, 0, 0);
        add_hilo_row(rtype(mips_pkg::fn_mult, 0), 32'hffff_fffe, 32'h3, 32'hffff_ffff, 32'hffff_fffa);
        add_hilo_row(rtype(mips_pkg::fn_multu, 0), 32'hffff_fffe, 32'h3, 32'h2, 32'hffff_fffa);
        add_hilo_row(rtype(mips_pkg::fn_mthi, 0), 32'h1111_1111, 0, 32'h1111_1111, 32'hffff_fffa);
        add_hilo_row(rtype(mips_pkg::fn_mtlo, 0), 32'h2222_2222, 0, 32'h1111_1111, 32'h2222_2222);
        add_hilo_row(32'h0, 32'h0, 32'h0, 32'h1111_1111, 32'h2222_2222);
        add_hilo_row({mips_pkg::op_j, 26'h40}, 32'd5, 32'd6, 32'h1111_1111, 32'h2222_2222);

        // quiet during reset and after release
        idle_cycles(16, 32'h0, 32'h0);
        arst_n = 1'b1;
        idle_cycles(4, 32'h0, 32'h0);

        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        idle_cycles(4, 32'h1111_1111, 32'h2222_2222);
        random_pass(24);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: tb.f
hdl/mips_pkg.sv
hdl/ex_stage_if.sv
hdl/alu_decoder.sv
hdl/alu.sv
hdl/hilo_unit.sv
hdl/exec_slice.sv
test/exec_slice_tb.sv

// File: Bender.yml
package:
  name: exec_slice

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/ex_stage_if.sv
      - hdl/alu_decoder.sv
      - hdl/alu.sv
      - hdl/hilo_unit.sv
      - hdl/exec_slice.sv
  - target: test
    files:
      - test/exec_slice_tb.sv
